// ==== logic/ex_op_pkg.sv ====
/*
  operator encodings and request bundles for the execute stage units.
  the ALU and the multiplier each take one packed request word,
  driven straight from the ID/EX register.
*/

`default_nettype none

package ex_op_pkg;

  // datapath width of the integer core
  localparam int unsigned XLEN = 32;

  //////////////////////////////////////////////////
  // ALU operators
  //////////////////////////////////////////////////

  // the last six are branch compares, they drive the decision bit
  typedef enum logic [3:0] {
    ALU_ADD  = 4'h0,
    ALU_SUB  = 4'h1,
    ALU_AND  = 4'h2,
    ALU_OR   = 4'h3,
    ALU_XOR  = 4'h4,
    ALU_SLL  = 4'h5,
    ALU_SRL  = 4'h6,
    ALU_SRA  = 4'h7,
    ALU_SLT  = 4'h8,
    ALU_SLTU = 4'h9,
    ALU_EQ   = 4'ha,
    ALU_NE   = 4'hb,
    ALU_LT   = 4'hc,
    ALU_GE   = 4'hd,
    ALU_LTU  = 4'he,
    ALU_GEU  = 4'hf
  } alu_op_e;

  //////////////////////////////////////////////////
  // multiplier operators
  //////////////////////////////////////////////////

  // MUL and MAC finish in one cycle, the high products iterate
  typedef enum logic [2:0] {
    MULT_MUL    = 3'd0,
    MULT_MAC    = 3'd1,
    MULT_MULH   = 3'd2,
    MULT_MULHSU = 3'd3,
    MULT_MULHU  = 3'd4
  } mult_op_e;

  // operand c is the jump target for the ALU
  typedef struct packed {
    alu_op_e         op;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] c;
  } alu_req_t;

  // operand c is the MAC addend
  typedef struct packed {
    mult_op_e        op;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] c;
  } mult_req_t;

endpackage

`default_nettype wire

// ==== logic/ex_wb_pkg.sv ====
/*
  register file write port definitions.
  one struct describes both the forwarding port (ALU side)
  and the load/store port coming out of the EX/WB register.
*/

`default_nettype none

package ex_wb_pkg;

  // 64 registers addressable, the upper half is reserved for extensions
  localparam int unsigned REG_ADDR_W = 6;

  //////////////////////////////////////////////////
  // write port
  //////////////////////////////////////////////////

  // we qualifies addr and data
  // data is a full register word
  typedef struct packed {
    logic                  we;
    logic [REG_ADDR_W-1:0] addr;
    logic [31:0]           data;
  } wb_port_t;

endpackage

`default_nettype wire

// ==== logic/ex_alu.sv ====
/*
  integer ALU of the execute stage.
  purely combinational: add/sub, logic, shifts, set-less-than,
  plus the six branch compares that feed the branch decision.
*/

`timescale 1ns/1ps
`default_nettype none

module ex_alu
  import ex_op_pkg::*;
(
  input  alu_req_t        req_i,
  output logic [XLEN-1:0] result_o,
  output logic            cmp_result_o
);

  // shift amount from the low bits of b only
  logic [4:0] shamt;

  // shared comparator outputs
  logic is_eq;
  logic is_lt_s;
  logic is_lt_u;

  assign shamt = req_i.b[4:0];

  //////////////////////////////////////////////////
  // comparator
  //////////////////////////////////////////////////

  assign is_eq   = (req_i.a == req_i.b);
  assign is_lt_s = ($signed(req_i.a) < $signed(req_i.b));
  assign is_lt_u = (req_i.a < req_i.b);

  // branch decision, low for every non-compare operator
  always_comb begin
    case (req_i.op)
      ALU_EQ:  cmp_result_o = is_eq;
      ALU_NE:  cmp_result_o = ~is_eq;
      ALU_LT:  cmp_result_o = is_lt_s;
      ALU_GE:  cmp_result_o = ~is_lt_s;
      ALU_LTU: cmp_result_o = is_lt_u;
      ALU_GEU: cmp_result_o = ~is_lt_u;
      default: cmp_result_o = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////
  // result mux
  //////////////////////////////////////////////////

  always_comb begin
    case (req_i.op)
      // arithmetic
      ALU_ADD: result_o = req_i.a + req_i.b;
      ALU_SUB: result_o = req_i.a - req_i.b;

      // bitwise logic
      ALU_AND: result_o = req_i.a & req_i.b;
      ALU_OR:  result_o = req_i.a | req_i.b;
      ALU_XOR: result_o = req_i.a ^ req_i.b;

      // shifts, arithmetic right keeps the sign of a
      ALU_SLL: result_o = req_i.a << shamt;
      ALU_SRL: result_o = req_i.a >> shamt;
      ALU_SRA: result_o = $unsigned($signed(req_i.a) >>> shamt);

      // set-less-than gives 0 or 1
      ALU_SLT:  result_o = {{(XLEN-1){1'b0}}, is_lt_s};
      ALU_SLTU: result_o = {{(XLEN-1){1'b0}}, is_lt_u};

      // compares also land in the result word, zero extended
      default: result_o = {{(XLEN-1){1'b0}}, cmp_result_o};
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/ex_mult.sv ====
/*
  integer multiplier of the execute stage.
  MUL/MAC give the low word in the same cycle. MULH, MULHSU and MULHU
  iterate over MULH_STEPS slices of b and hold the upper word until
  the stage accepts it through ex_ready_i.
*/

`timescale 1ns/1ps
`default_nettype none

module ex_mult
  import ex_op_pkg::*;
#(
  parameter int unsigned MULH_STEPS = 4
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            enable_i,
  input  mult_req_t       req_i,
  input  logic            ex_ready_i,
  output logic [XLEN-1:0] result_o,
  output logic            multicycle_o,
  output logic            ready_o
);

  // bits of b consumed per step
  localparam int unsigned CHUNK_W = XLEN / MULH_STEPS;
  localparam int unsigned CNT_W   = $clog2(MULH_STEPS + 1);
  localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(MULH_STEPS - 1);

  typedef enum logic [1:0] {ST_IDLE, ST_STEP, ST_DONE} state_e;

  state_e            state_q;
  state_e            state_d;
  logic [CNT_W-1:0]  cnt_q;
  logic [CNT_W-1:0]  cur_cnt;
  logic [2*XLEN-1:0] a_q;
  logic [2*XLEN-1:0] acc_q;
  logic [2*XLEN-1:0] cur_a;
  logic [2*XLEN-1:0] cur_acc;
  logic [2*XLEN-1:0] chunk_ext;
  logic [2*XLEN-1:0] acc_nxt;
  logic [XLEN-1:0]   b_q;
  logic [XLEN-1:0]   cur_b;
  logic [XLEN-1:0]   prod_lo;
  logic              b_signed_q;
  logic              cur_b_signed;
  logic              a_signed;
  logic              b_signed;
  logic              start_hi;
  logic              step_en;
  logic              last_step;
  logic              chunk_sign;

  assign a_signed = (req_i.op == MULT_MULH) || (req_i.op == MULT_MULHSU);
  assign b_signed = (req_i.op == MULT_MULH);
  assign start_hi = enable_i && (state_q == ST_IDLE) &&
                    (req_i.op inside {MULT_MULH, MULT_MULHSU, MULT_MULHU});
  assign step_en  = start_hi || (state_q == ST_STEP);

  //////////////////////////////////////////////////
  // iterative high product
  //////////////////////////////////////////////////

  // first slice comes straight from the request, later ones from the regs
  always_comb begin
    if (state_q == ST_IDLE) begin
      cur_a        = {{XLEN{a_signed & req_i.a[XLEN-1]}}, req_i.a};
      cur_b        = req_i.b;
      cur_b_signed = b_signed;
      cur_acc      = '0;
      cur_cnt      = '0;
    end else begin
      cur_a        = a_q;
      cur_b        = b_q;
      cur_b_signed = b_signed_q;
      cur_acc      = acc_q;
      cur_cnt      = cnt_q;
    end
  end

  // only the top slice of a signed b carries weight -2^(k*W)
  assign last_step  = (cur_cnt == LAST_STEP);
  assign chunk_sign = last_step & cur_b_signed & cur_b[CHUNK_W-1];
  assign chunk_ext  = {{(2*XLEN-CHUNK_W){chunk_sign}}, cur_b[CHUNK_W-1:0]};
  assign acc_nxt    = cur_acc + cur_a * chunk_ext;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: if (start_hi) state_d = last_step ? ST_DONE : ST_STEP;
      ST_STEP: if (last_step) state_d = ST_DONE;
      // hold the result until the stage moves on
      ST_DONE: if (ex_ready_i) state_d = ST_IDLE;
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (step_en) begin
        cnt_q <= cur_cnt + 1'b1;
      end
    end
  end

  // a moves up and b moves down by one slice per step
  always_ff @(posedge clk) begin
    if (step_en) begin
      a_q        <= cur_a << CHUNK_W;
      b_q        <= cur_b >> CHUNK_W;
      b_signed_q <= cur_b_signed;
      acc_q      <= acc_nxt;
    end
  end

  //////////////////////////////////////////////////
  // outputs
  //////////////////////////////////////////////////

  // single-cycle low product, truncated to XLEN
  assign prod_lo = req_i.a * req_i.b;

  always_comb begin
    if (state_q == ST_DONE) begin
      result_o = acc_q[2*XLEN-1:XLEN];
    end else if (req_i.op == MULT_MAC) begin
      result_o = prod_lo + req_i.c;
    end else begin
      result_o = prod_lo;
    end
  end

  assign ready_o      = (state_q == ST_DONE) || ((state_q == ST_IDLE) && !start_hi);
  assign multicycle_o = start_hi || (state_q != ST_IDLE);

endmodule

`default_nettype wire

// ==== logic/ex_wb_reg.sv ====
/*
  EX/WB pipeline register for the load/store write port.
  keeps the write enable and target register of the instruction that
  left EX; the data is the load result arriving in WB.
*/

`timescale 1ns/1ps
`default_nettype none

module ex_wb_reg
  import ex_wb_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  ex_valid_i,
  input  logic                  wb_ready_i,
  input  logic                  regfile_we_i,
  input  logic [REG_ADDR_W-1:0] regfile_waddr_i,
  input  logic [31:0]           lsu_rdata_i,
  output wb_port_t              port_o
);

  logic                  we_q;
  logic [REG_ADDR_W-1:0] waddr_q;

  //////////////////////////////////////////////////
  // write enable
  //////////////////////////////////////////////////

  // ex_valid_i already implies wb_ready_i
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      we_q <= 1'b0;
    end else if (ex_valid_i) begin
      we_q <= regfile_we_i;
    end else if (wb_ready_i) begin
      // WB took the old one and nothing new came, drop it
      we_q <= 1'b0;
    end
  end

  // address only follows a writing instruction
  always_ff @(posedge clk) begin
    if (ex_valid_i && regfile_we_i) begin
      waddr_q <= regfile_waddr_i;
    end
  end

  //////////////////////////////////////////////////
  // port
  //////////////////////////////////////////////////

  assign port_o.we   = we_q;
  assign port_o.addr = waddr_q;
  // load data shows up during WB, taken as is
  assign port_o.data = lsu_rdata_i;

endmodule

`default_nettype wire

// ==== logic/ex_stage.sv ====
/*
  execute stage top level.
  hosts the ALU, the multiplier and the EX/WB register, forms the
  forwarding write port and the ready/valid handshake towards ID and WB.
*/

`timescale 1ns/1ps
`default_nettype none

module ex_stage
  import ex_op_pkg::*;
  import ex_wb_pkg::*;
#(
  parameter int unsigned MULH_STEPS = 4
) (
  input  logic                  clk,
  input  logic                  rst_n,
  // ALU and multiplier requests from ID
  input  logic                  alu_en_i,
  input  alu_req_t              alu_req_i,
  input  logic                  mult_en_i,
  input  mult_req_t             mult_req_i,
  // CSR and LSU
  input  logic                  csr_access_i,
  input  logic [31:0]           csr_rdata_i,
  input  logic                  lsu_en_i,
  input  logic [31:0]           lsu_rdata_i,
  input  logic                  lsu_ready_ex_i,
  input  logic                  branch_in_ex_i,
  // destination registers
  input  logic                  regfile_alu_we_i,
  input  logic [REG_ADDR_W-1:0] regfile_alu_waddr_i,
  input  logic                  regfile_we_i,
  input  logic [REG_ADDR_W-1:0] regfile_waddr_i,
  input  logic                  wb_ready_i,
  // write ports
  output wb_port_t              fw_port_o,
  output wb_port_t              lsu_port_o,
  // to IF
  output logic                  branch_decision_o,
  output logic [XLEN-1:0]       jump_target_o,
  // stall control
  output logic                  mult_multicycle_o,
  output logic                  ex_ready_o,
  output logic                  ex_valid_o
);

  logic [XLEN-1:0] alu_result;
  logic [XLEN-1:0] mult_result;
  logic            alu_cmp_result;
  logic            mult_ready;
  logic            units_ready;

  //////////////////////////////////////////////////
  // units
  //////////////////////////////////////////////////

  ex_alu u_alu (
    .req_i        (alu_req_i),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp_result)
  );

  ex_mult #(
    .MULH_STEPS (MULH_STEPS)
  ) u_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (mult_en_i),
    .req_i        (mult_req_i),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .multicycle_o (mult_multicycle_o),
    .ready_o      (mult_ready)
  );

  ex_wb_reg u_wb_reg (
    .clk             (clk),
    .rst_n           (rst_n),
    .ex_valid_i      (ex_valid_o),
    .wb_ready_i      (wb_ready_i),
    .regfile_we_i    (regfile_we_i),
    .regfile_waddr_i (regfile_waddr_i),
    .lsu_rdata_i     (lsu_rdata_i),
    .port_o          (lsu_port_o)
  );

  //////////////////////////////////////////////////
  // forwarding port and handshake
  //////////////////////////////////////////////////

  // CSR read wins over mult, mult wins over ALU
  always_comb begin
    fw_port_o.we   = regfile_alu_we_i;
    fw_port_o.addr = regfile_alu_waddr_i;
    if (csr_access_i) begin
      fw_port_o.data = csr_rdata_i;
    end else if (mult_en_i) begin
      fw_port_o.data = mult_result;
    end else if (alu_en_i) begin
      fw_port_o.data = alu_result;
    end else begin
      fw_port_o.data = '0;
    end
  end

  assign branch_decision_o = alu_cmp_result;
  assign jump_target_o     = alu_req_i.c;

  // a branch resolves in EX, so it never waits for WB
  assign units_ready = mult_ready & lsu_ready_ex_i & wb_ready_i;
  assign ex_ready_o  = units_ready | branch_in_ex_i;
  assign ex_valid_o  = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i) & units_ready;

endmodule

`default_nettype wire

// ==== test/ex_ref_model.svh ====
/*
  expected results for the execute stage testbench.
  included inside the testbench module, after the package imports.
*/

`ifndef EX_REF_MODEL_SVH
`define EX_REF_MODEL_SVH

// signed less-than decided by the sign bits first
function automatic logic branch_taken(input alu_op_e op, input logic [31:0] a,
                                      input logic [31:0] b);
  logic lt_u;
  logic lt_s;
  lt_u = (a < b);
  lt_s = (a[31] != b[31]) ? a[31] : lt_u;
  case (op)
    ALU_EQ:  return a == b;
    ALU_NE:  return a != b;
    ALU_LT:  return lt_s;
    ALU_GE:  return !lt_s;
    ALU_LTU: return lt_u;
    ALU_GEU: return !lt_u;
    default: return 1'b0;
  endcase
endfunction

function automatic logic [31:0] alu_result_of(input alu_op_e op, input logic [31:0] a,
                                              input logic [31:0] b);
  logic [63:0] sra_full;
  // arithmetic shift through a sign extended double word
  sra_full = {{32{a[31]}}, a} >> b[4:0];
  case (op)
    ALU_ADD:  return a + b;
    ALU_SUB:  return a + ~b + 32'd1;
    ALU_AND:  return a & b;
    ALU_OR:   return a | b;
    ALU_XOR:  return a ^ b;
    ALU_SLL:  return a << b[4:0];
    ALU_SRL:  return a >> b[4:0];
    ALU_SRA:  return sra_full[31:0];
    ALU_SLT:  return {31'd0, branch_taken(ALU_LT, a, b)};
    ALU_SLTU: return {31'd0, branch_taken(ALU_LTU, a, b)};
    default:  return {31'd0, branch_taken(op, a, b)};
  endcase
endfunction

// all five products from one 64-bit multiply of extended operands
function automatic logic [31:0] mult_result_of(input mult_op_e op, input logic [31:0] a,
                                               input logic [31:0] b, input logic [31:0] c);
  logic [63:0] a_ext;
  logic [63:0] b_ext;
  logic [63:0] prod;
  a_ext = {{32{a[31] && (op == MULT_MULH || op == MULT_MULHSU)}}, a};
  b_ext = {{32{b[31] && (op == MULT_MULH)}}, b};
  prod  = a_ext * b_ext;
  case (op)
    MULT_MUL: return prod[31:0];
    MULT_MAC: return prod[31:0] + c;
    default:  return prod[63:32];
  endcase
endfunction

`endif

// ==== test/ex_stage_tb.sv ====
/*
  testbench for the execute stage.
  drives ALU, branch, multiply, CSR and load traffic into the DUT;
  assertions compare the ports against the reference model.
*/

`timescale 1ns/1ps
`default_nettype none

module ex_stage_tb
  import ex_op_pkg::*;
  import ex_wb_pkg::*;
();

  `include "ex_ref_model.svh"

  localparam int TIMEOUT = 200;

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic                  alu_en, mult_en, csr_access, lsu_en;
  logic                  lsu_ready_ex, branch_in_ex, wb_ready;
  alu_req_t              alu_req;
  mult_req_t             mult_req;
  logic [31:0]           csr_rdata, lsu_rdata, jump_target;
  logic                  rf_alu_we, rf_we;
  logic [REG_ADDR_W-1:0] rf_alu_waddr, rf_waddr;
  wb_port_t              fw_port, lsu_port;
  logic                  branch_decision, mult_multicycle, ex_ready, ex_valid;

  integer seed = 32'h94a9_d356;
  int     errors = 0;
  int     errors_at_start;
  int     tests_run = 0;
  int     tests_failed = 0;
  string  test_name = "reset";

  always #4 clk = ~clk;

  ex_stage u_dut (
    .clk (clk), .rst_n (rst_n),
    .alu_en_i (alu_en), .alu_req_i (alu_req),
    .mult_en_i (mult_en), .mult_req_i (mult_req),
    .csr_access_i (csr_access), .csr_rdata_i (csr_rdata),
    .lsu_en_i (lsu_en), .lsu_rdata_i (lsu_rdata), .lsu_ready_ex_i (lsu_ready_ex),
    .branch_in_ex_i (branch_in_ex),
    .regfile_alu_we_i (rf_alu_we), .regfile_alu_waddr_i (rf_alu_waddr),
    .regfile_we_i (rf_we), .regfile_waddr_i (rf_waddr),
    .wb_ready_i (wb_ready),
    .fw_port_o (fw_port), .lsu_port_o (lsu_port),
    .branch_decision_o (branch_decision), .jump_target_o (jump_target),
    .mult_multicycle_o (mult_multicycle),
    .ex_ready_o (ex_ready), .ex_valid_o (ex_valid)
  );

  //////////////////////////////////////////////////
  // concurrent checks
  //////////////////////////////////////////////////

  // stalled WB holds the stage unless a branch resolves
  assert property (@(posedge clk) disable iff (!rst_n)
    (!wb_ready && !branch_in_ex) |-> (!ex_valid && !ex_ready))
    else begin
      errors++;
      $display("%s: stage moved while wb_ready_i was low", test_name);
    end

  // load/store port picks up a writing instruction one cycle later
  assert property (@(posedge clk) disable iff (!rst_n)
    (ex_valid && rf_we) |=> (lsu_port.we && lsu_port.addr == $past(rf_waddr)))
    else begin
      errors++;
      $display("%s: load/store port missed a writing instruction", test_name);
    end

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  task automatic compare_word(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
    assert (actual === expected)
      else begin
        errors++;
        $display("error %s %s: expected %h actual %h", test_name, what, expected, actual);
      end
  endtask

  task automatic require_flag(input logic cond, input string problem);
    assert (cond)
      else begin
        errors++;
        $display("%s: %s", test_name, problem);
      end
  endtask

  task automatic start_test(input string name);
    test_name       = name;
    errors_at_start = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors != errors_at_start) tests_failed++;
    $display("%s finished with %0d errors", test_name, errors - errors_at_start);
  endtask

  function automatic alu_req_t random_alu_req(input alu_op_e op);
    alu_req_t r;
    r.op = op;
    r.a  = $random(seed);
    r.b  = $random(seed);
    r.c  = $random(seed);
    return r;
  endfunction

  function automatic mult_req_t random_mult_req(input mult_op_e op);
    mult_req_t r;
    r.op = op;
    r.a  = $random(seed);
    r.b  = $random(seed);
    r.c  = $random(seed);
    return r;
  endfunction

  // back to a quiet stage with WB ready
  task automatic go_idle();
    @(posedge clk);
    alu_en       <= 1'b0;
    mult_en      <= 1'b0;
    csr_access   <= 1'b0;
    lsu_en       <= 1'b0;
    branch_in_ex <= 1'b0;
    rf_alu_we    <= 1'b0;
    rf_we        <= 1'b0;
    wb_ready     <= 1'b1;
  endtask

  // one negedge per step, the iteration keeps the stage stalled meanwhile
  task automatic wait_for_valid();
    int cycles;
    cycles = 0;
    while (!ex_valid && cycles < TIMEOUT) begin
      require_flag(!ex_ready && mult_multicycle, "high product did not stall the stage");
      @(negedge clk);
      cycles++;
    end
    if (!ex_valid) begin
      $display("timed out waiting for ex_valid_o in %s", test_name);
      $display("test failed");
      $finish;
    end
  endtask

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  initial begin
    int                    i;
    alu_req_t              req;
    mult_req_t             mreq;
    logic [31:0]           word;
    logic [REG_ADDR_W-1:0] waddr;
    rst_n        = 1'b0;
    alu_en       = 1'b0;
    mult_en      = 1'b0;
    csr_access   = 1'b0;
    lsu_en       = 1'b0;
    lsu_ready_ex = 1'b1;
    branch_in_ex = 1'b0;
    wb_ready     = 1'b1;
    alu_req      = '0;
    mult_req     = '0;
    csr_rdata    = '0;
    lsu_rdata    = '0;
    rf_alu_we    = 1'b0;
    rf_alu_waddr = 6'd5;
    rf_we        = 1'b0;
    rf_waddr     = '0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    start_test("reset");
    require_flag(!lsu_port.we && !mult_multicycle, "outputs not cleared by reset");
    require_flag(ex_ready, "multiplier not ready after reset");
    end_test();

    start_test("alu_random");
    for (i = 0; i < 32; i++) begin
      req   = random_alu_req(alu_op_e'(i % 16));
      waddr = $random(seed);
      @(posedge clk);
      alu_req      <= req;
      alu_en       <= 1'b1;
      rf_alu_we    <= i[0];
      rf_alu_waddr <= waddr;
      @(negedge clk);
      compare_word("fw data", alu_result_of(req.op, req.a, req.b), fw_port.data);
      // enable and address pass straight through to the forwarding port
      compare_word("fw we", {31'd0, i[0]}, {31'd0, fw_port.we});
      compare_word("fw addr", 32'(waddr), 32'(fw_port.addr));
      require_flag(ex_valid, "ex_valid_o low for an ALU operation");
    end
    end_test();

    start_test("branch_compare");
    for (i = 0; i < 24; i++) begin
      req = random_alu_req(alu_op_e'(10 + i % 6));
      // second half repeats every compare with equal operands
      if (i >= 12) req.b = req.a;
      @(posedge clk);
      alu_req      <= req;
      branch_in_ex <= 1'b1;
      @(negedge clk);
      compare_word("branch decision", {31'd0, branch_taken(req.op, req.a, req.b)},
                   {31'd0, branch_decision});
      compare_word("jump target", req.c, jump_target);
    end
    go_idle();
    end_test();

    start_test("mul_mac");
    for (i = 0; i < 16; i++) begin
      mreq = random_mult_req(mult_op_e'(i % 2));
      @(posedge clk);
      mult_req <= mreq;
      mult_en  <= 1'b1;
      @(negedge clk);
      require_flag(ex_ready && ex_valid, "single-cycle product stalled the stage");
      compare_word("product", mult_result_of(mreq.op, mreq.a, mreq.b, mreq.c), fw_port.data);
    end
    end_test();

    start_test("high_product");
    for (i = 0; i < 12; i++) begin
      mreq = random_mult_req(mult_op_e'(2 + i % 3));
      // extreme operands in the first round of each operator
      if (i < 3) begin
        mreq.a = 32'h8000_0000;
        mreq.b = (i == 1) ? 32'hffff_ffff : 32'h8000_0000;
      end
      @(posedge clk);
      mult_req <= mreq;
      mult_en  <= 1'b1;
      @(negedge clk);
      require_flag(!ex_valid, "high product finished in its first cycle");
      wait_for_valid();
      compare_word("upper product", mult_result_of(mreq.op, mreq.a, mreq.b, mreq.c),
                   fw_port.data);
    end
    go_idle();
    end_test();

    start_test("backpressure_csr");
    word = $random(seed);
    @(posedge clk);
    wb_ready   <= 1'b0;
    alu_en     <= 1'b1;
    csr_access <= 1'b1;
    csr_rdata  <= word;
    alu_req    <= random_alu_req(ALU_ADD);
    for (i = 0; i < 4; i++) begin
      @(negedge clk);
      require_flag(!ex_valid && !ex_ready, "stage did not stall under back-pressure");
      compare_word("csr data", word, fw_port.data);
    end
    @(posedge clk);
    wb_ready <= 1'b1;
    @(negedge clk);
    require_flag(ex_valid && ex_ready, "stage did not resume after back-pressure");
    compare_word("csr data", word, fw_port.data);
    go_idle();
    end_test();

    start_test("lsu_port");
    waddr = $random(seed);
    word  = $random(seed);
    @(posedge clk);
    lsu_en   <= 1'b1;
    rf_we    <= 1'b1;
    rf_waddr <= waddr;
    @(negedge clk);
    require_flag(ex_valid, "load did not leave the stage");
    @(posedge clk);
    lsu_en    <= 1'b0;
    rf_we     <= 1'b0;
    lsu_rdata <= word;
    @(negedge clk);
    require_flag(lsu_port.we, "load/store write enable missing");
    compare_word("lsu addr", waddr, lsu_port.addr);
    compare_word("lsu data", word, lsu_port.data);
    // idle cycle with WB ready drops the enable
    @(negedge clk);
    require_flag(!lsu_port.we, "write enable not cleared after an idle cycle");
    end_test();

    $display("tests run %0d, failing %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+test
logic/ex_op_pkg.sv
logic/ex_wb_pkg.sv
logic/ex_alu.sv
logic/ex_mult.sv
logic/ex_wb_reg.sv
logic/ex_stage.sv
test/ex_stage_tb.sv

// ==== Bender.yml ====
package:
  name: ex_stage

sources:
  - logic/ex_op_pkg.sv
  - logic/ex_wb_pkg.sv
  - logic/ex_alu.sv
  - logic/ex_mult.sv
  - logic/ex_wb_reg.sv
  - logic/ex_stage.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/ex_stage_tb.sv
